// ==== hw/arm_config.svh ====
`ifndef ARM_CONFIG_SVH
`define ARM_CONFIG_SVH

// datapath and instruction widths
`define ARM_DATA_W 32
`define ARM_INSTR_W 32

// register file geometry
`define ARM_REG_ADDR_W 4

// r0..r14 are stored, r15 is the pc
`define ARM_NUM_REGS 15

// program counter
`define ARM_PC_STEP 4

// an r15 read sees two instructions ahead
`define ARM_PC_READ_OFFSET 8

`endif

// ==== hw/arm_pkg.sv ====
`default_nettype none

`include "arm_config.svh"

package arm_pkg;

    typedef logic [`ARM_DATA_W-1:0] word_t;
    typedef logic [`ARM_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        AND,
        EOR,
        SUB,
        ADD,
        ORR,
        MOV
    } alu_op_e;

    // encoding matches instruction bits 6:5
    typedef enum logic [1:0] {
        LSL = 2'b00,
        LSR = 2'b01,
        ASR = 2'b10,
        ROR = 2'b11
    } shift_e;

    // decode to execute
    typedef struct packed {
        logic      valid;
        alu_op_e   alu_op;
        logic      imm_sel;
        shift_e    shift_kind;
        logic [4:0] shamt;
        reg_addr_t rn;
        reg_addr_t rm;
        reg_addr_t rd;
        word_t     rn_val;
        word_t     rm_val;
        word_t     imm;
    } exec_op_t;

    // execute to write-back
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     result;
    } wb_op_t;

endpackage

`default_nettype wire

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "arm_config.svh"

module fetch_stage (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire arm_pkg::word_t instr,
    output arm_pkg::word_t     pc,
    output arm_pkg::word_t     instr_f,
    output arm_pkg::word_t     instr_pc_f,
    output logic               fetch_valid
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc          <= '0;
            fetch_valid <= 1'b0;
        end else begin
            pc          <= pc + arm_pkg::word_t'(`ARM_PC_STEP);
            fetch_valid <= 1'b1;
        end
    end

    // instruction word and the address it came from
    always_ff @(posedge clk) begin
        instr_f    <= instr;
        instr_pc_f <= pc;
    end

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "arm_config.svh"

module reg_file (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire arm_pkg::reg_addr_t ra1,
    input  wire arm_pkg::reg_addr_t ra2,
    output arm_pkg::word_t          rd1,
    output arm_pkg::word_t          rd2,
    input  wire arm_pkg::word_t     pc_read,
    input  wire logic               we,
    input  wire arm_pkg::reg_addr_t wa,
    input  wire arm_pkg::word_t     wd
);

    localparam arm_pkg::reg_addr_t PC_IDX = arm_pkg::reg_addr_t'(`ARM_NUM_REGS);

    arm_pkg::word_t regs [`ARM_NUM_REGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `ARM_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != PC_IDX) begin
            regs[wa] <= wd;
        end
    end

    // r15 takes priority over the write-first bypass
    assign rd1 = (ra1 == PC_IDX) ? pc_read :
                 (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == PC_IDX) ? pc_read :
                 (we && wa == ra2) ? wd : regs[ra2];

endmodule

`default_nettype wire

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "arm_config.svh"

module decode_stage (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire arm_pkg::word_t    instr_f,
    input  wire arm_pkg::word_t    instr_pc_f,
    input  wire logic              fetch_valid,
    input  wire arm_pkg::wb_op_t   wb,
    output arm_pkg::exec_op_t      dec_op
);

    logic [`ARM_INSTR_W-1:0] ir;
    logic [1:0]              op;
    logic [3:0]              cmd;
    arm_pkg::reg_addr_t      rn;
    arm_pkg::reg_addr_t      rd;
    arm_pkg::reg_addr_t      rm;
    arm_pkg::word_t          rn_val;
    arm_pkg::word_t          rm_val;
    arm_pkg::word_t          pc_read;
    arm_pkg::alu_op_e        alu_op;
    logic                    cmd_ok;

    assign ir  = instr_f;
    assign op  = ir[27:26];
    assign cmd = ir[24:21];
    assign rn  = ir[19:16];
    assign rd  = ir[15:12];
    assign rm  = ir[3:0];

    assign pc_read = instr_pc_f + arm_pkg::word_t'(`ARM_PC_READ_OFFSET);

    ////////////////////////////////////////////////////////////////////
    // command decode
    always_comb begin
        cmd_ok = 1'b1;
        alu_op = arm_pkg::AND;
        case (cmd)
            4'b0000: alu_op = arm_pkg::AND;
            4'b0001: alu_op = arm_pkg::EOR;
            4'b0010: alu_op = arm_pkg::SUB;
            4'b0100: alu_op = arm_pkg::ADD;
            4'b1100: alu_op = arm_pkg::ORR;
            4'b1101: alu_op = arm_pkg::MOV;
            default: cmd_ok = 1'b0;
        endcase
    end

    reg_file u_reg_file (
        .clk     (clk),
        .reset   (reset),
        .ra1     (rn),
        .ra2     (rm),
        .rd1     (rn_val),
        .rd2     (rm_val),
        .pc_read (pc_read),
        .we      (wb.valid),
        .wa      (wb.rd),
        .wd      (wb.result)
    );

    // rd of 15 would be a pc write, not supported
    always_comb begin
        dec_op.valid      = fetch_valid && (op == 2'b00) && cmd_ok && (rd != 4'd15);
        dec_op.alu_op     = alu_op;
        dec_op.imm_sel    = ir[25];
        dec_op.shift_kind = arm_pkg::shift_e'(ir[6:5]);
        dec_op.shamt      = ir[11:7];
        dec_op.rn         = rn;
        dec_op.rm         = rm;
        dec_op.rd         = rd;
        dec_op.rn_val     = rn_val;
        dec_op.rm_val     = rm_val;
        dec_op.imm        = {{(`ARM_DATA_W-8){1'b0}}, ir[7:0]};
    end

endmodule

`default_nettype wire

// ==== hw/pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

// one pipeline stage, the payload carries its own valid bit
module pipe_reg #(
    parameter type item_t = logic
) (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire item_t d,
    output item_t      q
);

    // all zeros also drops the valid bit
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// ==== hw/barrel_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module barrel_shifter (
    input  wire arm_pkg::word_t  value,
    input  wire arm_pkg::shift_e kind,
    input  wire logic [4:0]      amount,
    output arm_pkg::word_t       shifted
);

    logic [63:0] doubled;

    // rotate via a doubled word, low half is the result
    assign doubled = {value, value} >> amount;

    // amount 0 falls out as a pass-through for every kind
    always_comb begin
        case (kind)
            arm_pkg::LSL: shifted = value << amount;
            arm_pkg::LSR: shifted = value >> amount;
            arm_pkg::ASR: shifted = arm_pkg::word_t'($signed(value) >>> amount);
            arm_pkg::ROR: shifted = doubled[31:0];
            default:      shifted = value;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire arm_pkg::alu_op_e op,
    input  wire arm_pkg::word_t   a,
    input  wire arm_pkg::word_t   b,
    output arm_pkg::word_t        result
);

    // add and sub wrap mod 2^32, no flags kept
    always_comb begin
        case (op)
            arm_pkg::AND: result = a & b;
            arm_pkg::EOR: result = a ^ b;
            arm_pkg::SUB: result = a - b;
            arm_pkg::ADD: result = a + b;
            arm_pkg::ORR: result = a | b;
            // mov ignores rn
            arm_pkg::MOV: result = b;
            default:      result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire arm_pkg::exec_op_t ex_op,
    input  wire arm_pkg::wb_op_t   wb,
    output arm_pkg::wb_op_t        ex_result
);

    arm_pkg::word_t rn_fwd;
    arm_pkg::word_t rm_fwd;
    arm_pkg::word_t rm_shifted;
    arm_pkg::word_t op2;
    arm_pkg::word_t alu_result;

    ////////////////////////////////////////////////////////////////////
    // forwarding from write-back
    // a valid wb item never has rd 15, so r15 reads are left alone
    assign rn_fwd = (wb.valid && wb.rd == ex_op.rn) ? wb.result : ex_op.rn_val;
    assign rm_fwd = (wb.valid && wb.rd == ex_op.rm) ? wb.result : ex_op.rm_val;

    barrel_shifter u_shifter (
        .value   (rm_fwd),
        .kind    (ex_op.shift_kind),
        .amount  (ex_op.shamt),
        .shifted (rm_shifted)
    );

    // operand 2
    assign op2 = ex_op.imm_sel ? ex_op.imm : rm_shifted;

    alu u_alu (
        .op     (ex_op.alu_op),
        .a      (rn_fwd),
        .b      (op2),
        .result (alu_result)
    );

    always_comb begin
        ex_result.valid  = ex_op.valid;
        ex_result.rd     = ex_op.rd;
        ex_result.result = alu_result;
    end

endmodule

`default_nettype wire

// ==== hw/arm_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module arm_core (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire arm_pkg::word_t instr,
    output arm_pkg::word_t      pc,
    output logic                wb_valid,
    output arm_pkg::reg_addr_t  wb_reg,
    output arm_pkg::word_t      wb_data
);

    arm_pkg::word_t    instr_f;
    arm_pkg::word_t    instr_pc_f;
    logic              fetch_valid;
    arm_pkg::exec_op_t dec_op;
    arm_pkg::exec_op_t ex_op;
    arm_pkg::wb_op_t   ex_result;
    arm_pkg::wb_op_t   wb_op;

    ////////////////////////////////////////////////////////////////////
    // fetch and decode
    fetch_stage u_fetch (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .pc          (pc),
        .instr_f     (instr_f),
        .instr_pc_f  (instr_pc_f),
        .fetch_valid (fetch_valid)
    );

    decode_stage u_decode (
        .clk         (clk),
        .reset       (reset),
        .instr_f     (instr_f),
        .instr_pc_f  (instr_pc_f),
        .fetch_valid (fetch_valid),
        .wb          (wb_op),
        .dec_op      (dec_op)
    );

    ////////////////////////////////////////////////////////////////////
    // execute and write-back
    pipe_reg #(.item_t(arm_pkg::exec_op_t)) u_ex_reg (
        .clk   (clk),
        .reset (reset),
        .d     (dec_op),
        .q     (ex_op)
    );

    execute_stage u_execute (
        .ex_op     (ex_op),
        .wb        (wb_op),
        .ex_result (ex_result)
    );

    pipe_reg #(.item_t(arm_pkg::wb_op_t)) u_wb_reg (
        .clk   (clk),
        .reset (reset),
        .d     (ex_result),
        .q     (wb_op)
    );

    // retired write
    assign wb_valid = wb_op.valid;
    assign wb_reg   = wb_op.rd;
    assign wb_data  = wb_op.result;

endmodule

`default_nettype wire

// ==== bench/arm_core_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "arm_config.svh"

module arm_core_assert (
    input wire logic               clk,
    input wire logic               reset,
    input wire arm_pkg::word_t     pc,
    input wire logic               wb_valid,
    input wire arm_pkg::reg_addr_t wb_reg
);

    wb_valid_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(wb_valid))
        else $error("wb_valid is unknown");

    // r15 is never a destination
    no_pc_write: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> wb_reg != 4'd15)
        else $error("write-back to r15 retired");

    pc_steps: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> pc == $past(pc) + arm_pkg::word_t'(`ARM_PC_STEP))
        else $error("pc did not advance by one instruction");

endmodule

bind arm_core arm_core_assert u_assert (
    .clk      (clk),
    .reset    (reset),
    .pc       (pc),
    .wb_valid (wb_valid),
    .wb_reg   (wb_reg)
);

`default_nettype wire

// ==== bench/arm_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "arm_config.svh"

module arm_core_tb;

    localparam int MEM_WORDS = 64;
    localparam int RETIRE_LIMIT = 32;
    localparam int DRAIN_CYCLES = 10;
    // op field 10, never a data-processing word
    localparam arm_pkg::word_t NON_DP_WORD = 32'hE800_0000;

    logic               clk;
    logic               reset;
    arm_pkg::word_t     instr;
    arm_pkg::word_t     pc;
    logic               wb_valid;
    arm_pkg::reg_addr_t wb_reg;
    arm_pkg::word_t     wb_data;

    arm_pkg::word_t     imem [MEM_WORDS];
    arm_pkg::word_t     model_regs [`ARM_NUM_REGS];
    arm_pkg::reg_addr_t exp_reg [$];
    arm_pkg::word_t     exp_data [$];
    arm_pkg::word_t     exp_pc [$];
    integer             seed;

    arm_core u_dut (
        .clk      (clk),
        .reset    (reset),
        .instr    (instr),
        .pc       (pc),
        .wb_valid (wb_valid),
        .wb_reg   (wb_reg),
        .wb_data  (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // instruction memory read, one word per fetch
    always @(negedge clk) begin
        if (pc < MEM_WORDS * 4)
            instr <= imem[pc[31:2]];
        else
            instr <= NON_DP_WORD;
    end

    //////////////////////////////////////////////////////////////////////
    // random program

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    function automatic logic [3:0] supported_cmd(input int k);
        case (k)
            0:       return 4'b0000;
            1:       return 4'b0001;
            2:       return 4'b0010;
            3:       return 4'b0100;
            4:       return 4'b1100;
            default: return 4'b1101;
        endcase
    endfunction

    // low registers are favoured so that results get reused soon
    function automatic arm_pkg::reg_addr_t pick_reg();
        int k;
        k = rand_below(8);
        if (k < 5)
            return arm_pkg::reg_addr_t'(rand_below(4));
        if (k == 5)
            return 4'd15;
        return arm_pkg::reg_addr_t'(rand_below(15));
    endfunction

    function automatic arm_pkg::word_t make_instr(input int idx);
        logic [1:0]         op;
        logic               imm;
        logic [3:0]         cmd;
        logic [4:0]         shamt;
        logic [1:0]         sh;
        logic [7:0]         imm8;
        arm_pkg::reg_addr_t rn;
        arm_pkg::reg_addr_t rd;
        arm_pkg::reg_addr_t rm;
        arm_pkg::word_t     w;
        op    = (rand_below(8) == 0) ? 2'(1 + rand_below(2)) : 2'b00;
        cmd   = (rand_below(8) == 0) ? 4'(rand_below(16)) : supported_cmd(rand_below(6));
        imm   = 1'(rand_below(2));
        rn    = pick_reg();
        rd    = pick_reg();
        rm    = pick_reg();
        shamt = (rand_below(4) == 0) ? 5'd0 : 5'(rand_below(32));
        sh    = 2'(rand_below(4));
        imm8  = 8'(rand_below(256));
        // opening words cover every alu op and every shift kind
        if (idx < 10) begin
            op  = 2'b00;
            rd  = arm_pkg::reg_addr_t'(idx % 4);
            imm = (idx < 6);
            cmd = (idx < 6) ? supported_cmd(idx) : 4'b0100;
            sh  = 2'(idx - 6);
            if (idx == 6)
                shamt = 5'd0;
        end
        w = {4'hE, op, imm, cmd, 1'b0, rn, rd, 12'h000};
        w[11:0] = imm ? {4'h0, imm8} : {shamt, sh, 1'b0, rm};
        w[4] = 1'b0;
        return w;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference model

    function automatic arm_pkg::word_t shift_ref(input arm_pkg::word_t v,
                                                 input logic [1:0] sh,
                                                 input logic [4:0] n);
        arm_pkg::word_t res;
        res = v;
        // one bit position per step
        for (int i = 0; i < n; i++) begin
            case (sh)
                2'b00:   res = {res[30:0], 1'b0};
                2'b01:   res = {1'b0, res[31:1]};
                2'b10:   res = {res[31], res[31:1]};
                default: res = {res[0], res[31:1]};
            endcase
        end
        return res;
    endfunction

    function automatic arm_pkg::word_t read_ref(input arm_pkg::reg_addr_t r,
                                                input arm_pkg::word_t addr);
        return (r == 4'd15) ? addr + 32'd8 : model_regs[r];
    endfunction

    task automatic run_model();
        arm_pkg::word_t w;
        arm_pkg::word_t addr;
        arm_pkg::word_t a;
        arm_pkg::word_t b;
        arm_pkg::word_t res;
        logic           ok;
        for (int i = 0; i < `ARM_NUM_REGS; i++)
            model_regs[i] = '0;
        for (int idx = 0; idx < MEM_WORDS; idx++) begin
            w    = imem[idx];
            addr = arm_pkg::word_t'(idx * 4);
            a    = read_ref(w[19:16], addr);
            b    = w[25] ? {24'h0, w[7:0]} : shift_ref(read_ref(w[3:0], addr), w[6:5], w[11:7]);
            ok   = 1'b1;
            case (w[24:21])
                4'b0000: res = a & b;
                4'b0001: res = a ^ b;
                4'b0010: res = a - b;
                4'b0100: res = a + b;
                4'b1100: res = a | b;
                4'b1101: res = b;
                default: ok = 1'b0;
            endcase
            // skipped words leave no retirement
            if (ok && w[27:26] == 2'b00 && w[15:12] != 4'd15) begin
                model_regs[w[15:12]] = res;
                exp_reg.push_back(w[15:12]);
                exp_data.push_back(res);
                exp_pc.push_back(addr + 32'd12);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // checks

    task automatic stop_on_failure();
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_reg(input arm_pkg::reg_addr_t got, input arm_pkg::reg_addr_t exp,
                             input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s, got r%0d, expected r%0d", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_word(input arm_pkg::word_t got, input arm_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic wait_retire();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (wb_valid !== 1'b1) begin
            if (cycles >= RETIRE_LIMIT) begin
                $display("no register write retired within %0d cycles", RETIRE_LIMIT);
                stop_on_failure();
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    initial begin
        arm_pkg::reg_addr_t r;
        arm_pkg::word_t     d;
        arm_pkg::word_t     p;
        reset = 1'b1;
        instr = NON_DP_WORD;
        seed  = 39982;
        for (int i = 0; i < MEM_WORDS; i++)
            imem[i] = make_instr(i);
        run_model();

        repeat (2) @(posedge clk);
        @(negedge clk);
        reset <= 1'b0;
        check_word(pc, 32'd0, "pc after reset");

        // retirements come in program order, three edges after fetch
        while (exp_reg.size() > 0) begin
            r = exp_reg.pop_front();
            d = exp_data.pop_front();
            p = exp_pc.pop_front();
            wait_retire();
            check_word(pc, p, $sformatf("pc at retirement of instruction at %h", p - 32'd12));
            check_reg(wb_reg, r, $sformatf("destination of instruction at %h", p - 32'd12));
            check_word(wb_data, d, $sformatf("result of instruction at %h", p - 32'd12));
        end

        repeat (DRAIN_CYCLES) begin
            @(negedge clk);
            if (wb_valid !== 1'b0) begin
                $display("a register write retired after the last expected one");
                stop_on_failure();
            end
        end
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hw
hw/arm_pkg.sv
hw/fetch_stage.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/pipe_reg.sv
hw/barrel_shifter.sv
hw/alu.sv
hw/execute_stage.sv
hw/arm_core.sv
bench/arm_core_assert.sv
bench/arm_core_tb.sv
